// ==== compile.f ====
src/dcache_pkg.sv
src/dcache_lines.sv
src/miss_table.sv
src/dcache_req.sv
src/dcache_top.sv
tb/tb_memory.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the data cache testbench with Verilator and run it
# exit status is zero only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -Mdir obj_dir -f compile.f &&
./obj_dir/Vdcache_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int    PERIOD        = 40;
    localparam int    NUM_LINES     = 8;
    localparam int    NUM_MISS      = 4;
    localparam int    DIRECTED_OPS  = 40;
    localparam int    RANDOM_OPS    = 300;
    localparam int    STALL_LIMIT   = 400;
    localparam int    RANDOM_BLOCKS = NUM_LINES + 4;
    localparam addr_t RANDOM_BASE   = 16'h3000;

    logic       clock;
    logic       reset;
    logic       load_valid;
    load_req_t  load_req;
    logic       load_ready;
    load_rsp_t  load_rsp;
    logic       store_valid;
    store_req_t store_req;
    logic       store_ready;
    logic       drained;
    logic       mem_grant;
    mem_rsp_t   mem_rsp;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       grant_enable;
    logic [7:0] shadow [0:65535];
    int         value_errors = 0;
    int         stall_errors = 0;
    int         load_checks = 0;

    dcache_top #(.NUM_LINES(NUM_LINES), .NUM_MISS(NUM_MISS)) dcache_top_i (
        .clock, .reset, .load_valid, .load_req, .load_ready, .load_rsp, .store_valid,
        .store_req, .store_ready, .drained, .mem_grant, .mem_rsp, .mem_req_valid, .mem_req
    );

    tb_memory #(.LATENCY(6)) memory_i (
        .clock, .grant_enable, .mem_req_valid, .mem_req, .mem_grant, .mem_rsp
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] initial_byte(input addr_t a);
        return (a[7:0] * 8'd3) ^ a[15:8] ^ 8'h5a;
    endfunction

    // little endian, zero extended
    function automatic logic [31:0] expected_load(input addr_t a, input mem_size_e size);
        logic [31:0] v;
        v = {24'b0, shadow[a]};
        if (size != SIZE_BYTE) begin
            v[15:8] = shadow[a + 16'd1];
        end
        if (size == SIZE_WORD) begin
            v[23:16] = shadow[a + 16'd2];
            v[31:24] = shadow[a + 16'd3];
        end
        return v;
    endfunction

    function automatic void update_shadow(input store_req_t req);
        int n;
        n = (req.size == SIZE_BYTE) ? 1 : (req.size == SIZE_HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            shadow[req.addr + addr_t'(k)] = req.value[k*8 +: 8];
        end
    endfunction

    task automatic check_load(input load_req_t req, input load_rsp_t got);
        logic [31:0] exp;
        exp = expected_load(req.addr, req.size);
        load_checks++;
        if (got.value !== exp) begin
            $display("ERR %0t: load %h size %0d returned %h, expected %h",
                     $time, req.addr, req.size, got.value, exp);
            value_errors++;
        end
    endtask

    task automatic check_block(input block_addr_t blk, input block_t got);
        for (int k = 0; k < 8; k++) begin
            if (got.bytes[k] !== shadow[{blk, 3'(k)}]) begin
                $display("ERR %0t: memory block %h byte %0d is %h, expected %h",
                         $time, blk, k, got.bytes[k], shadow[{blk, 3'(k)}]);
                value_errors++;
            end
        end
    endtask

    // nothing held, nothing queued, so the bus is quiet and drained is up
    task automatic check_idle(input string where);
        if (load_ready !== 1'b0 || store_ready !== 1'b0 || mem_req_valid !== 1'b0 ||
            drained !== 1'b1) begin
            $display("ERR %0t: %s, load_ready %b store_ready %b mem_req_valid %b drained %b",
                     $time, where, load_ready, store_ready, mem_req_valid, drained);
            value_errors++;
        end
    endtask

    // loads checked and stores recorded at the handshake edge, loads first
    always @(posedge clock) begin
        if (!reset && load_valid && load_ready) begin
            check_load(load_req, load_rsp);
        end
        if (!reset && store_valid && store_ready) begin
            update_shadow(store_req);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers, entered on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic request_load(input addr_t a, input mem_size_e size);
        int waited;
        waited = 0;
        load_req = '{addr: a, size: size};
        load_valid = 1'b1;
        @(posedge clock);
        while (!load_ready && waited < STALL_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (!load_ready) begin
            $display("load at %h was not accepted within %0d cycles", a, STALL_LIMIT);
            stall_errors++;
        end
        @(negedge clock);
        load_valid = 1'b0;
    endtask

    task automatic send_store(input addr_t a, input mem_size_e size, input logic [31:0] v);
        int waited;
        waited = 0;
        store_req = '{addr: a, size: size, value: v};
        store_valid = 1'b1;
        @(posedge clock);
        while (!store_ready && waited < STALL_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (!store_ready) begin
            $display("store at %h was not accepted within %0d cycles", a, STALL_LIMIT);
            stall_errors++;
        end
        @(negedge clock);
        store_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(posedge clock);
        while (!drained && waited < STALL_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        if (!drained) begin
            $display("write-throughs did not drain within %0d cycles", STALL_LIMIT);
            stall_errors++;
        end
        @(negedge clock);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int        blk;
        int        off;
        mem_size_e size;
        addr_t     addr;
        void'($urandom(32'hc097_a58a));
        for (int a = 0; a < 65536; a++) begin
            shadow[a] = initial_byte(addr_t'(a));
        end
        reset = 1'b1;
        load_valid = 1'b0;
        load_req = '0;
        store_valid = 1'b0;
        store_req = '0;
        grant_enable = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_idle("outputs not idle after reset");

        // cold misses through the fill path
        request_load(16'h0100, SIZE_WORD);
        request_load(16'h0208, SIZE_HALF);
        request_load(16'h0311, SIZE_BYTE);
        request_load(16'h1ff8, SIZE_WORD);

        // every offset of one line
        for (int k = 0; k < 8; k++) begin
            request_load(16'h0400 + addr_t'(k), SIZE_BYTE);
        end
        for (int k = 0; k < 8; k += 2) begin
            request_load(16'h0400 + addr_t'(k), SIZE_HALF);
        end
        for (int k = 0; k < 8; k += 4) begin
            request_load(16'h0400 + addr_t'(k), SIZE_WORD);
        end

        // store hits, merge and write-through
        send_store(16'h0404, SIZE_WORD, 32'hdead_beef);
        request_load(16'h0404, SIZE_WORD);
        send_store(16'h0401, SIZE_BYTE, 32'h0000_00a5);
        send_store(16'h0406, SIZE_HALF, 32'h0000_1234);
        request_load(16'h0400, SIZE_WORD);
        request_load(16'h0404, SIZE_WORD);
        wait_drained();
        check_block(block_of(16'h0400), memory_i.contents[block_of(16'h0400)]);

        // write-allocate
        send_store(16'h2a10, SIZE_WORD, 32'h0bad_cafe);
        request_load(16'h2a10, SIZE_WORD);
        request_load(16'h2a12, SIZE_HALF);
        wait_drained();
        check_block(block_of(16'h2a10), memory_i.contents[block_of(16'h2a10)]);

        // random mix over more blocks than lines
        for (int n = 0; n < RANDOM_OPS; n++) begin
            blk = $urandom_range(RANDOM_BLOCKS - 1);
            size = mem_size_e'($urandom_range(2));
            off = $urandom_range(7);
            if (size == SIZE_HALF) begin
                off = off & 6;
            end else if (size == SIZE_WORD) begin
                off = off & 4;
            end
            addr = RANDOM_BASE + addr_t'(blk * 8 + off);
            if ($urandom_range(2) == 0) begin
                send_store(addr, size, $urandom());
            end else begin
                request_load(addr, size);
            end
        end
        wait_drained();
        for (int b = 0; b < RANDOM_BLOCKS; b++) begin
            check_block(block_of(RANDOM_BASE) + block_addr_t'(b),
                        memory_i.contents[block_of(RANDOM_BASE) + block_addr_t'(b)]);
        end

        // bus back-pressure, write parked while grant is low
        request_load(16'h0500, SIZE_WORD);
        grant_enable = 1'b0;
        send_store(16'h0500, SIZE_WORD, 32'h1357_9bdf);
        fork
            send_store(16'h0504, SIZE_WORD, 32'h2468_ace0);
            begin
                repeat (40) begin
                    @(posedge clock);
                    if (store_ready || drained) begin
                        $display("ERR %0t: store taken or drained high with grant low", $time);
                        value_errors++;
                    end
                end
                @(negedge clock);
                grant_enable = 1'b1;
            end
        join
        request_load(16'h0500, SIZE_WORD);
        request_load(16'h0504, SIZE_WORD);
        wait_drained();
        check_block(block_of(16'h0500), memory_i.contents[block_of(16'h0500)]);
        check_idle("bus still requesting after all traffic completed");

        $display("load checks: %0d, value errors: %0d, stalled requests: %0d",
                 load_checks, value_errors, stall_errors);
        if (value_errors == 0 && stall_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // generous budget per operation
    initial begin
        repeat ((DIRECTED_OPS + RANDOM_OPS) * 200) @(posedge clock);
        $display("watchdog expired, the run did not finish in %0d cycles",
                 (DIRECTED_OPS + RANDOM_OPS) * 200);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== tb/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory
    import dcache_pkg::*;
#(
    parameter int LATENCY = 6
) (
    input  logic     clock,
    input  logic     grant_enable,
    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    output logic     mem_grant,
    output mem_rsp_t mem_rsp
);

    logic [63:0] contents [0:8191];
    logic [63:0] read_data [0:15];
    int          age [0:15];
    logic [15:0] busy;
    mem_tag_t    next_tag;
    mem_tag_t    accept_tag;
    logic        grant_roll;
    logic        reply_valid;
    mem_tag_t    reply_tag;
    logic [63:0] reply_data;
    logic        accepted;
    mem_tag_t    acc_tag;
    mem_req_t    acc_req;

    // preload value, mixes all address bits
    function automatic logic [7:0] initial_byte(input addr_t a);
        return (a[7:0] * 8'd3) ^ a[15:8] ^ 8'h5a;
    endfunction

    assign mem_grant = grant_enable && grant_roll;

    // tag handed back in the cycle the request is taken, zero when refused
    assign accept_tag = (mem_req_valid && mem_grant && !busy[next_tag]) ? next_tag : '0;

    assign mem_rsp = '{rsp_tag: accept_tag, valid: reply_valid, tag: reply_tag,
                       data: reply_data};

    initial begin
        for (int b = 0; b < 8192; b++) begin
            for (int k = 0; k < 8; k++) begin
                contents[b][k*8 +: 8] = initial_byte(addr_t'(b * 8 + k));
            end
        end
        busy = '0;
        next_tag = 4'd1;
        grant_roll = 1'b0;
        reply_valid = 1'b0;
        reply_tag = '0;
        reply_data = '0;
        forever begin
            // handshake as the DUT sees it at this edge
            @(posedge clock);
            accepted = accept_tag != '0;
            acc_tag = accept_tag;
            acc_req = mem_req;
            @(negedge clock);
            if (reply_valid) begin
                busy[reply_tag] = 1'b0;
            end
            reply_valid = 1'b0;
            if (accepted) begin
                if (acc_req.cmd == MEM_STORE) begin
                    contents[acc_req.addr[15:3]] = acc_req.data;
                end
                read_data[acc_tag] = contents[acc_req.addr[15:3]];
                busy[acc_tag] = 1'b1;
                age[acc_tag] = 0;
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            // one reply per cycle
            for (int t = 1; t < 16; t++) begin
                if (busy[t]) begin
                    age[t] = age[t] + 1;
                    if (!reply_valid && age[t] >= LATENCY) begin
                        reply_valid = 1'b1;
                        reply_tag = mem_tag_t'(t);
                        reply_data = read_data[t];
                    end
                end
            end
            grant_roll = $urandom_range(3) != 0;
        end
    end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_LINES = 8,
    parameter int NUM_MISS  = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       load_valid,
    input  load_req_t  load_req,
    output logic       load_ready,
    output load_rsp_t  load_rsp,
    input  logic       store_valid,
    input  store_req_t store_req,
    output logic       store_ready,
    output logic       drained,
    input  logic       mem_grant,
    input  mem_rsp_t   mem_rsp,
    output logic       mem_req_valid,
    output mem_req_t   mem_req
);

    logic   load_hit;
    logic   store_hit;
    logic   load_touch;
    logic   store_commit;
    logic   load_fill_pending;
    logic   store_fill_pending;
    logic   write_slot_ok;
    logic   alloc_load_fill;
    logic   alloc_store_fill;
    logic   alloc_write;
    block_t merged_block;
    fill_t  fill;

    dcache_lines #(.NUM_LINES(NUM_LINES)) dcache_lines_i (
        .clock, .reset, .load_valid, .load_req, .store_req, .load_touch,
        .store_commit, .fill, .load_hit, .store_hit, .load_data(load_rsp), .merged_block
    );

    miss_table #(.NUM_MISS(NUM_MISS)) miss_table_i (
        .clock, .reset, .load_req, .store_req, .alloc_load_fill, .alloc_store_fill,
        .alloc_write, .write_block(merged_block), .mem_grant, .mem_rsp,
        .load_fill_pending, .store_fill_pending, .write_slot_ok, .drained,
        .mem_req_valid, .mem_req, .fill
    );

    dcache_req dcache_req_i (
        .load_valid, .store_valid, .load_hit, .store_hit, .load_fill_pending,
        .store_fill_pending, .write_slot_ok, .drained, .load_ready, .store_ready,
        .load_touch, .store_commit, .alloc_load_fill, .alloc_store_fill, .alloc_write
    );

endmodule

// ==== src/dcache_req.sv ====
`timescale 1ns/1ps

module dcache_req (
    input  logic load_valid,
    input  logic store_valid,
    input  logic load_hit,
    input  logic store_hit,
    input  logic load_fill_pending,
    input  logic store_fill_pending,
    input  logic write_slot_ok,
    input  logic drained,
    output logic load_ready,
    output logic store_ready,
    output logic load_touch,
    output logic store_commit,
    output logic alloc_load_fill,
    output logic alloc_store_fill,
    output logic alloc_write
);

    logic store_ok;

    //////////////////////////////////////////////////////////////////////
    // load side
    //////////////////////////////////////////////////////////////////////

    // load_hit already includes load_valid
    assign load_ready = load_hit;

    // a hit refreshes the line in the LRU order
    assign load_touch = load_hit;

    // miss with nothing in flight for that block
    assign alloc_load_fill = load_valid && !load_hit && !load_fill_pending;

    //////////////////////////////////////////////////////////////////////
    // store side
    //////////////////////////////////////////////////////////////////////

    // a hit still waits while an older write-through is unsent
    assign store_ok = store_valid && store_hit && write_slot_ok && drained;

    assign store_ready = store_ok;

    // line merge and write-through queue together
    assign store_commit = store_ok;
    assign alloc_write = store_ok;

    // write-allocate on a miss, then retried by the queue
    assign alloc_store_fill = store_valid && !store_hit && !store_fill_pending;

endmodule

// ==== src/miss_table.sv ====
`timescale 1ns/1ps

module miss_table
    import dcache_pkg::*;
#(
    parameter int NUM_MISS = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  load_req_t  load_req,
    input  store_req_t store_req,
    input  logic       alloc_load_fill,
    input  logic       alloc_store_fill,
    input  logic       alloc_write,
    input  block_t     write_block,
    input  logic       mem_grant,
    input  mem_rsp_t   mem_rsp,
    output logic       load_fill_pending,
    output logic       store_fill_pending,
    output logic       write_slot_ok,
    output logic       drained,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    output fill_t      fill
);

    localparam int IDX_W = $clog2(NUM_MISS);
    localparam int CNT_W = $clog2(NUM_MISS + 1);

    typedef struct packed {
        logic        valid;
        logic        sent;
        mem_tag_t    tag;
        block_addr_t blk;
        block_t      data;
        miss_op_e    op;
    } miss_entry_t;

    typedef miss_entry_t [NUM_MISS-1:0] entry_arr_t;

    entry_arr_t       entries_q;
    entry_arr_t       entries_d;
    logic             issue_found;
    logic [IDX_W-1:0] issue_idx;
    logic             send_now;
    logic             rsp_hit;
    logic [IDX_W-1:0] rsp_idx;
    logic [CNT_W-1:0] free_cnt;
    logic [IDX_W-1:0] slot0;
    logic [IDX_W-1:0] slot1;
    logic [IDX_W-1:0] store_slot;
    logic             load_take;
    logic             store_fill_take;
    logic             fold_found;
    logic [IDX_W-1:0] fold_idx;
    logic             tag_clash;

    //////////////////////////////////////////////////////////////////////
    // issue, write-throughs ahead of fills
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        issue_found = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < NUM_MISS; i++) begin
            if (!issue_found && entries_q[i].valid && !entries_q[i].sent &&
                entries_q[i].op == MISS_WRITE) begin
                issue_found = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < NUM_MISS; i++) begin
            if (!issue_found && entries_q[i].valid && !entries_q[i].sent) begin
                issue_found = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
        mem_req = '{cmd: MEM_NONE, addr: '0, data: '0};
        if (issue_found) begin
            mem_req.cmd = (entries_q[issue_idx].op == MISS_WRITE) ? MEM_STORE : MEM_LOAD;
            mem_req.addr = {entries_q[issue_idx].blk, 3'b000};
            mem_req.data = entries_q[issue_idx].data.dword;
        end
    end

    assign mem_req_valid = issue_found;
    // zero response tag means the memory did not take it
    assign send_now = issue_found && mem_grant && (mem_rsp.rsp_tag != '0);

    // reply lookup by tag
    always_comb begin
        rsp_hit = 1'b0;
        rsp_idx = '0;
        for (int i = 0; i < NUM_MISS; i++) begin
            if (!rsp_hit && mem_rsp.valid && entries_q[i].valid && entries_q[i].sent &&
                entries_q[i].tag == mem_rsp.tag) begin
                rsp_hit = 1'b1;
                rsp_idx = IDX_W'(i);
            end
        end
    end

    assign fill.valid = rsp_hit && entries_q[rsp_idx].op != MISS_WRITE;
    assign fill.blk = entries_q[rsp_idx].blk;
    assign fill.data = mem_rsp.data;

    //////////////////////////////////////////////////////////////////////
    // status towards request steering
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        load_fill_pending = 1'b0;
        // a load fill of the same block in this cycle covers the store too
        store_fill_pending = alloc_load_fill &&
                             block_of(load_req.addr) == block_of(store_req.addr);
        drained = 1'b1;
        free_cnt = '0;
        slot0 = '0;
        slot1 = '0;
        fold_found = 1'b0;
        fold_idx = '0;
        tag_clash = 1'b0;
        for (int i = 0; i < NUM_MISS; i++) begin
            if (entries_q[i].valid && entries_q[i].op != MISS_WRITE) begin
                load_fill_pending |= entries_q[i].blk == block_of(load_req.addr);
                store_fill_pending |= entries_q[i].blk == block_of(store_req.addr);
            end
            if (entries_q[i].valid && !entries_q[i].sent && entries_q[i].op == MISS_WRITE) begin
                drained = 1'b0;
                // the entry on the bus right now keeps its data
                if (!fold_found && entries_q[i].blk == block_of(store_req.addr) &&
                    !(issue_found && issue_idx == IDX_W'(i))) begin
                    fold_found = 1'b1;
                    fold_idx = IDX_W'(i);
                end
            end
            if (!entries_q[i].valid) begin
                if (free_cnt == '0) begin
                    slot0 = IDX_W'(i);
                end else if (free_cnt == CNT_W'(1)) begin
                    slot1 = IDX_W'(i);
                end
                free_cnt = free_cnt + 1'b1;
            end
            for (int j = i + 1; j < NUM_MISS; j++) begin
                tag_clash |= entries_q[i].valid && entries_q[i].sent &&
                             entries_q[j].valid && entries_q[j].sent &&
                             entries_q[i].tag == entries_q[j].tag;
            end
        end
    end

    // the store side takes the slot after the load
    assign load_take = alloc_load_fill && free_cnt != '0;
    assign store_slot = load_take ? slot1 : slot0;
    assign write_slot_ok = fold_found || free_cnt > CNT_W'(load_take);
    assign store_fill_take = alloc_store_fill && free_cnt > CNT_W'(load_take);

    always_comb begin
        entries_d = entries_q;
        if (send_now) begin
            entries_d[issue_idx].sent = 1'b1;
            entries_d[issue_idx].tag = mem_rsp.rsp_tag;
        end
        if (rsp_hit) begin
            entries_d[rsp_idx].valid = 1'b0;
            entries_d[rsp_idx].sent = 1'b0;
        end
        if (load_take) begin
            entries_d[slot0] = '{1'b1, 1'b0, '0, block_of(load_req.addr), '0, MISS_LOAD_FILL};
        end
        if (store_fill_take) begin
            entries_d[store_slot] =
                '{1'b1, 1'b0, '0, block_of(store_req.addr), '0, MISS_STORE_FILL};
        end
        if (alloc_write) begin
            if (fold_found) begin
                entries_d[fold_idx].data = write_block;
            end else begin
                entries_d[store_slot] =
                    '{1'b1, 1'b0, '0, block_of(store_req.addr), write_block, MISS_WRITE};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_MISS; i++) begin
                entries_q[i].valid <= 1'b0;
                entries_q[i].sent <= 1'b0;
            end
        end else begin
            entries_q <= entries_d;
        end
    end

    // store side entries land on a free slot and never on the load's slot
    a_alloc_free: assert property (@(posedge clock) disable iff (reset)
        (store_fill_take || (alloc_write && !fold_found)) |->
            !entries_q[store_slot].valid && !(load_take && store_slot == slot0))
        else $error("allocation into an entry that is not free");

    a_tag_unique: assert property (@(posedge clock) disable iff (reset) !tag_clash)
        else $error("two outstanding entries share a bus tag");

endmodule

// ==== src/dcache_lines.sv ====
`timescale 1ns/1ps

module dcache_lines
    import dcache_pkg::*;
#(
    parameter int NUM_LINES = 8
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       load_valid,
    input  load_req_t  load_req,
    input  store_req_t store_req,
    input  logic       load_touch,
    input  logic       store_commit,
    input  fill_t      fill,
    output logic       load_hit,
    output logic       store_hit,
    output load_rsp_t  load_data,
    output block_t     merged_block
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam lru_cnt_t LRU_TOP = lru_cnt_t'(NUM_LINES - 1);

    typedef line_t [NUM_LINES-1:0] line_arr_t;

    line_arr_t            lines_q;
    line_arr_t            filled;
    line_arr_t            lines_d;
    logic                 installed;
    logic [NUM_LINES-1:0] load_match;
    logic [NUM_LINES-1:0] store_match;
    logic [IDX_W-1:0]     load_idx;
    logic [IDX_W-1:0]     store_idx;
    block_t               load_block;

    // most recent goes to the top, the ones above it move down by one
    function automatic line_arr_t touch(line_arr_t ls, logic [IDX_W-1:0] idx);
        lru_cnt_t  old_cnt;
        line_arr_t res;
        res = ls;
        old_cnt = ls[idx].lru;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (ls[i].lru > old_cnt) begin
                res[i].lru = ls[i].lru - 1'b1;
            end
        end
        res[idx].lru = LRU_TOP;
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // refill install, seen by this cycle's hit checks
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        filled = lines_q;
        installed = 1'b0;
        if (fill.valid) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                if (!installed && lines_q[i].lru == '0) begin
                    installed = 1'b1;
                    filled[i].valid = 1'b1;
                    filled[i].blk = fill.blk;
                    filled[i].lru = LRU_TOP;
                    filled[i].data = fill.data;
                end else if (lines_q[i].lru != '0) begin
                    filled[i].lru = lines_q[i].lru - 1'b1;
                end
            end
        end
    end

    // address match
    always_comb begin
        load_idx = '0;
        store_idx = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            load_match[i] = filled[i].valid && filled[i].blk == block_of(load_req.addr);
            store_match[i] = filled[i].valid && filled[i].blk == block_of(store_req.addr);
            if (load_match[i]) begin
                load_idx = IDX_W'(i);
            end
            if (store_match[i]) begin
                store_idx = IDX_W'(i);
            end
        end
    end

    assign load_hit = load_valid && |load_match;
    assign store_hit = |store_match;
    assign load_block = filled[load_idx].data;

    // sub-word extract, zero extended
    always_comb begin
        case (load_req.size)
            SIZE_BYTE: load_data.value = {24'b0, load_block.bytes[load_req.addr[2:0]]};
            SIZE_HALF: load_data.value = {16'b0, load_block.halves[load_req.addr[2:1]]};
            default:   load_data.value = load_block.words[load_req.addr[2]];
        endcase
    end

    // store merge into the hit block
    always_comb begin
        merged_block = filled[store_idx].data;
        case (store_req.size)
            SIZE_BYTE: merged_block.bytes[store_req.addr[2:0]] = store_req.value[7:0];
            SIZE_HALF: merged_block.halves[store_req.addr[2:1]] = store_req.value[15:0];
            default:   merged_block.words[store_req.addr[2]] = store_req.value;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // next state and registers
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        lines_d = filled;
        if (load_touch) begin
            lines_d = touch(lines_d, load_idx);
        end
        if (store_commit) begin
            lines_d[store_idx].data = merged_block;
            lines_d = touch(lines_d, store_idx);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // counters start as a permutation so one of them is always zero
            for (int i = 0; i < NUM_LINES; i++) begin
                lines_q[i].valid <= 1'b0;
                lines_q[i].lru <= lru_cnt_t'(i);
            end
        end else begin
            lines_q <= lines_d;
        end
    end

    // a fill never installs a block that is already cached
    a_one_match: assert property (@(posedge clock) disable iff (reset)
        (!load_valid || $onehot0(load_match)) && (!store_commit || $onehot0(store_match)))
        else $error("more than one line matches an address");

endmodule

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // addresses and data
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] addr_t;
    typedef logic [12:0] block_addr_t;
    typedef logic [3:0]  mem_tag_t;

    // wide enough for up to 256 lines
    typedef logic [7:0]  lru_cnt_t;

    typedef union packed {
        logic [63:0]       dword;
        logic [1:0][31:0]  words;
        logic [3:0][15:0]  halves;
        logic [7:0][7:0]   bytes;
    } block_t;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;
    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_cmd_e;
    typedef enum logic [1:0] {MISS_LOAD_FILL, MISS_STORE_FILL, MISS_WRITE} miss_op_e;

    //////////////////////////////////////////////////////////////////////
    // request and bus packets
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {addr_t addr; mem_size_e size;} load_req_t;
    typedef struct packed {addr_t addr; mem_size_e size; logic [31:0] value;} store_req_t;
    typedef struct packed {logic [31:0] value;} load_rsp_t;

    // addr is always 8-byte aligned
    typedef struct packed {mem_cmd_e cmd; addr_t addr; logic [63:0] data;} mem_req_t;

    // rsp_tag answers the current request, tag names a returning reply
    typedef struct packed {
        mem_tag_t    rsp_tag;
        logic        valid;
        mem_tag_t    tag;
        logic [63:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic        valid;
        block_addr_t blk;
        lru_cnt_t    lru;
        block_t      data;
    } line_t;

    typedef struct packed {logic valid; block_addr_t blk; block_t data;} fill_t;

    function automatic block_addr_t block_of(addr_t a);
        return a[15:3];
    endfunction

endpackage
